// File: logic/datapath_settings.svh
// datapath sizing constants shared by the package and the RTL blocks
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

// width of the bus, the registers and each ALU operand
`define DP_WORD_WIDTH 32

// general register file depth, select width is derived from it
`define DP_REG_COUNT 16

// shift-and-add iterations of the multiplier, one per operand bit
`define DP_MUL_STEPS `DP_WORD_WIDTH

`endif

// File: logic/datapathPkg.sv
// datapath package with the word types, ALU opcodes and strobe structs
`default_nettype none

`include "datapath_settings.svh"

package datapathPkg;

    typedef logic [`DP_WORD_WIDTH-1:0]       word_t;   // bus and register value
    typedef logic [2*`DP_WORD_WIDTH-1:0]     dword_t;  // full ALU result into RZ
    typedef logic [$clog2(`DP_REG_COUNT)-1:0] regSel_t;

    // opcodes as presented on opSelect
    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opAnd = 5'b00101,
        opOr  = 5'b00110,
        opMul = 5'b01110,
        opShl = 5'b11000,
        opShr = 5'b11001
    } aluOp_t;

    // out-strobes, at most one high in any cycle
    typedef struct packed {
        logic rf;
        logic pc;
        logic ir;
        logic ry;
        logic mdr;
        logic rzLo;
        logic rzHi;
        logic mar;
        logic hi;
        logic lo;
    } busSource_t;

    // load strobes plus the PC increment and the memory read select
    typedef struct packed {
        logic rf;
        logic pc;
        logic ir;
        logic ry;
        logic rz;
        logic mar;
        logic mdr;
        logic hi;
        logic lo;
        logic incPc;
        logic read;   // MDR takes mdataIn instead of the bus
    } regLoad_t;

endpackage

`default_nettype wire

// File: logic/registerFile.sv
// general register file, sixteen words with one shared read/write select
`timescale 1ns/1ps
`default_nettype none

`include "datapath_settings.svh"

module registerFile (
    input  logic               Clock,
    input  logic               rstN,
    input  datapathPkg::regSel_t regSel,
    input  logic               write,
    input  datapathPkg::word_t dataIn,
    output datapathPkg::word_t dataOut
);
    import datapathPkg::*;

    word_t regs [`DP_REG_COUNT];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[regSel] <= dataIn;   // bus value into the selected entry
        end
    end

    // read port shares the write select, so the bus sees the old value
    // until the edge that writes it
    assign dataOut = regs[regSel];

endmodule

`default_nettype wire

// File: logic/specialRegisters.sv
// named datapath registers: PC with incrementer, IR, MAR, MDR, HI, LO, RY and RZ
`timescale 1ns/1ps
`default_nettype none

module specialRegisters (
    input  logic                  Clock,
    input  logic                  rstN,
    input  datapathPkg::regLoad_t loadSel,
    input  datapathPkg::word_t    bus,
    input  datapathPkg::word_t    mdataIn,
    input  datapathPkg::dword_t   aluResult,
    output datapathPkg::word_t    pc,
    output datapathPkg::word_t    ir,
    output datapathPkg::word_t    mar,
    output datapathPkg::word_t    mdr,
    output datapathPkg::word_t    hi,
    output datapathPkg::word_t    lo,
    output datapathPkg::word_t    ry,
    output datapathPkg::word_t    rzLo,
    output datapathPkg::word_t    rzHi
);
    import datapathPkg::*;

    word_t mdrNext;

    // memory word or bus into MDR
    assign mdrNext = loadSel.read ? mdataIn : bus;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc   <= '0;
            ir   <= '0;
            mar  <= '0;
            mdr  <= '0;
            hi   <= '0;
            lo   <= '0;
            ry   <= '0;
            rzLo <= '0;
            rzHi <= '0;
        end else begin
            if (loadSel.pc) begin
                pc <= bus;              // a jump wins over the increment
            end else if (loadSel.incPc) begin
                pc <= pc + word_t'(1);
            end

            if (loadSel.ir) begin
                ir <= bus;
            end
            if (loadSel.mar) begin
                mar <= bus;
            end
            if (loadSel.mdr) begin
                mdr <= mdrNext;
            end
            if (loadSel.hi) begin
                hi <= bus;
            end
            if (loadSel.lo) begin
                lo <= bus;
            end
            if (loadSel.ry) begin
                ry <= bus;              // operand A latch for the ALU
            end
            if (loadSel.rz) begin
                {rzHi, rzLo} <= aluResult;
            end
        end
    end

    // the controller must never ask for a PC load and an increment in one step
    pcLoadOrIncrement: assert property (
        @(posedge Clock) disable iff (!rstN)
        !(loadSel.pc && loadSel.incPc)
    ) else $error("PC load and incPc high in the same cycle");

endmodule

`default_nettype wire

// File: logic/busMux.sv
// single bus multiplexer, drives the bus from the one selected register
`timescale 1ns/1ps
`default_nettype none

module busMux (
    input  logic                    Clock,   // sampling clock for the check below
    input  datapathPkg::busSource_t outSel,
    input  datapathPkg::word_t      rf,
    input  datapathPkg::word_t      pc,
    input  datapathPkg::word_t      ir,
    input  datapathPkg::word_t      ry,
    input  datapathPkg::word_t      mdr,
    input  datapathPkg::word_t      rzLo,
    input  datapathPkg::word_t      rzHi,
    input  datapathPkg::word_t      mar,
    input  datapathPkg::word_t      hi,
    input  datapathPkg::word_t      lo,
    output datapathPkg::word_t      bus
);

    // bus idles at zero when nothing drives it
    always_comb begin
        bus = '0;
        if (outSel.rf) begin
            bus = rf;
        end else if (outSel.pc) begin
            bus = pc;
        end else if (outSel.ir) begin
            bus = ir;
        end else if (outSel.ry) begin
            bus = ry;
        end else if (outSel.mdr) begin
            bus = mdr;
        end else if (outSel.rzLo) begin
            bus = rzLo;
        end else if (outSel.rzHi) begin
            bus = rzHi;
        end else if (outSel.mar) begin
            bus = mar;
        end else if (outSel.hi) begin
            bus = hi;
        end else if (outSel.lo) begin
            bus = lo;
        end
    end

    // two drivers at once would be a bus fight on real hardware
    singleBusDriver: assert property (
        @(posedge Clock) $onehot0(outSel)
    ) else $error("more than one bus out-strobe high: %b", outSel);

endmodule

`default_nettype wire

// File: logic/alu.sv
// ALU with single-cycle logic/arithmetic, bit-serial shifts and shift-and-add multiply
`timescale 1ns/1ps
`default_nettype none

`include "datapath_settings.svh"

module alu (
    input  logic                Clock,
    input  logic                rstN,
    input  datapathPkg::aluOp_t opSelect,
    input  logic                start,
    input  datapathPkg::word_t  a,
    input  datapathPkg::word_t  b,
    output datapathPkg::dword_t result,
    output logic                finished
);
    import datapathPkg::*;

    localparam int wordWidth  = `DP_WORD_WIDTH;
    localparam int countWidth = $clog2(`DP_MUL_STEPS);   // also covers the shift amount

    typedef enum logic [1:0] {
        idle,
        shifting,
        multiplying
    } aluState_t;

    aluState_t             state;
    logic [countWidth-1:0] stepCount;      // steps left, finish when it hits one
    logic [countWidth-1:0] shiftAmount;
    word_t                 mcand;          // multiplicand, A at start
    logic                  shiftLeft;      // direction latched at start
    logic                  leftDir;
    word_t                 shiftSrc;
    word_t                 shifted;
    word_t                 simpleResult;

    // one shift-and-add step, low half holds the remaining multiplier bits
    function automatic dword_t mulStep(dword_t prod, word_t m);
        logic [wordWidth:0] sum;
        if (prod[0]) begin
            sum = {1'b0, prod[2*wordWidth-1:wordWidth]} + {1'b0, m};
        end else begin
            sum = {1'b0, prod[2*wordWidth-1:wordWidth]};
        end
        return {sum, prod[wordWidth-1:1]};
    endfunction

    assign shiftAmount = b[countWidth-1:0];

    // one shared single-bit shifter, fed from A at start and from the result after
    assign shiftSrc = (state == idle) ? a : result[wordWidth-1:0];
    assign leftDir  = (state == idle) ? (opSelect == opShl) : shiftLeft;
    assign shifted  = leftDir ? (shiftSrc << 1) : (shiftSrc >> 1);

    always_comb begin
        case (opSelect)
            opAdd:   simpleResult = a + b;   // wraps at word width
            opSub:   simpleResult = a - b;
            opAnd:   simpleResult = a & b;
            opOr:    simpleResult = a | b;
            default: simpleResult = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state     <= idle;
            stepCount <= '0;
            mcand     <= '0;
            shiftLeft <= 1'b0;
            result    <= '0;
            finished  <= 1'b0;
        end else begin
            finished <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        mcand     <= a;
                        shiftLeft <= (opSelect == opShl);
                        if (opSelect == opMul) begin
                            // first step happens on the start edge
                            result    <= mulStep({{wordWidth{1'b0}}, b}, a);
                            stepCount <= countWidth'(`DP_MUL_STEPS - 1);
                            state     <= multiplying;
                        end else if (opSelect == opShl || opSelect == opShr) begin
                            if (shiftAmount == '0) begin
                                result   <= {{wordWidth{1'b0}}, a};
                                finished <= 1'b1;
                            end else if (shiftAmount == countWidth'(1)) begin
                                result   <= {{wordWidth{1'b0}}, shifted};
                                finished <= 1'b1;
                            end else begin
                                result    <= {{wordWidth{1'b0}}, shifted};
                                stepCount <= shiftAmount - 1'b1;
                                state     <= shifting;
                            end
                        end else begin
                            result   <= {{wordWidth{1'b0}}, simpleResult};
                            finished <= 1'b1;
                        end
                    end
                end
                shifting: begin
                    result    <= {{wordWidth{1'b0}}, shifted};
                    stepCount <= stepCount - 1'b1;
                    if (stepCount == countWidth'(1)) begin
                        finished <= 1'b1;
                        state    <= idle;
                    end
                end
                multiplying: begin
                    result    <= mulStep(result, mcand);
                    stepCount <= stepCount - 1'b1;
                    if (stepCount == countWidth'(1)) begin
                        finished <= 1'b1;   // 32nd step done
                        state    <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // a new start may only come once the previous operation has finished
    noStartWhileBusy: assert property (
        @(posedge Clock) disable iff (!rstN)
        start |-> (state == idle)
    ) else $error("ALU start while busy");

endmodule

`default_nettype wire

// File: logic/dataPath.sv
// single-bus datapath top, ties the register file, special registers, bus and ALU
`timescale 1ns/1ps
`default_nettype none

module dataPath (
    input  logic                    Clock,
    input  logic                    rstN,
    input  datapathPkg::busSource_t outSel,
    input  datapathPkg::regLoad_t   loadSel,
    input  datapathPkg::regSel_t    regSel,
    input  datapathPkg::aluOp_t     opSelect,
    input  logic                    start,
    input  datapathPkg::word_t      mdataIn,
    output datapathPkg::word_t      busOut,
    output logic                    finished
);
    import datapathPkg::*;

    word_t  rfOut;
    word_t  pc;
    word_t  ir;
    word_t  mar;
    word_t  mdr;
    word_t  hi;
    word_t  lo;
    word_t  ry;
    word_t  rzLo;
    word_t  rzHi;
    dword_t aluResult;

    registerFile u_registerFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .regSel  (regSel),
        .write   (loadSel.rf),
        .dataIn  (busOut),
        .dataOut (rfOut)
    );

    specialRegisters u_specialRegisters (
        .Clock     (Clock),
        .rstN      (rstN),
        .loadSel   (loadSel),
        .bus       (busOut),
        .mdataIn   (mdataIn),
        .aluResult (aluResult),
        .pc        (pc),
        .ir        (ir),
        .mar       (mar),
        .mdr       (mdr),
        .hi        (hi),
        .lo        (lo),
        .ry        (ry),
        .rzLo      (rzLo),
        .rzHi      (rzHi)
    );

    busMux u_busMux (
        .Clock  (Clock),
        .outSel (outSel),
        .rf     (rfOut),
        .pc     (pc),
        .ir     (ir),
        .ry     (ry),
        .mdr    (mdr),
        .rzLo   (rzLo),
        .rzHi   (rzHi),
        .mar    (mar),
        .hi     (hi),
        .lo     (lo),
        .bus    (busOut)
    );

    // operand A from RY, operand B straight off the bus
    alu u_alu (
        .Clock    (Clock),
        .rstN     (rstN),
        .opSelect (opSelect),
        .start    (start),
        .a        (ry),
        .b        (busOut),
        .result   (aluResult),
        .finished (finished)
    );

endmodule

`default_nettype wire

// File: verification/dataPathTb.sv
// datapath testbench that loads registers through MDR, runs ALU operations and checks the bus
`timescale 1ns/1ps
`default_nettype none

`include "datapath_settings.svh"

module dataPathTb;
    import datapathPkg::*;

    localparam int waitLimit = 100;   // cycles allowed for finished
    localparam busSource_t noSource = '0;
    localparam busSource_t fromRf   = '{rf: 1'b1, default: 1'b0};
    localparam busSource_t fromPc   = '{pc: 1'b1, default: 1'b0};
    localparam busSource_t fromIr   = '{ir: 1'b1, default: 1'b0};
    localparam busSource_t fromRzHi = '{rzHi: 1'b1, default: 1'b0};

    typedef struct {
        string   name;
        word_t   opA;
        word_t   opB;
        regSel_t dest;
        aluOp_t  op;
        word_t   expLo;
        word_t   expHi;
    } opRow_t;

    logic       Clock;
    logic       rstN;
    busSource_t outSel;
    regLoad_t   loadSel;
    regSel_t    regSel;
    aluOp_t     opSelect;
    logic       start;
    word_t      mdataIn;
    word_t      busOut;
    logic       finished;

    opRow_t opTable [$];
    word_t  regValues [`DP_REG_COUNT];
    int     checkCount;
    int     errorCount;
    int     timeoutCount;

    dataPath u_dataPath (
        .Clock    (Clock),
        .rstN     (rstN),
        .outSel   (outSel),
        .loadSel  (loadSel),
        .regSel   (regSel),
        .opSelect (opSelect),
        .start    (start),
        .mdataIn  (mdataIn),
        .busOut   (busOut),
        .finished (finished)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // low word wraps at 32 bits while multiply keeps the full 64-bit product
    function automatic dword_t expectedResult(aluOp_t op, word_t a, word_t b);
        word_t  low;
        dword_t full;
        case (op)
            opAdd:   low = a + b;
            opSub:   low = a - b;
            opAnd:   low = a & b;
            opOr:    low = a | b;
            opShl:   low = a << b[4:0];
            opShr:   low = a >> b[4:0];
            default: low = '0;
        endcase
        full = {word_t'(0), a} * {word_t'(0), b};
        if (op != opMul) begin
            full = {word_t'(0), low};
        end
        return full;
    endfunction

    // cycles from start to finished, a shift by zero still takes one
    function automatic int expectedLatency(aluOp_t op, word_t b);
        int amount;
        int cycles;
        amount = int'(b[4:0]);
        cycles = 1;
        if (op == opShl || op == opShr) begin
            cycles = (amount == 0) ? 1 : amount;
        end else if (op == opMul) begin
            cycles = `DP_MUL_STEPS;
        end
        return cycles;
    endfunction

    task automatic addRow(string name, word_t a, word_t b, regSel_t dest, aluOp_t op,
                          dword_t expected);
        opRow_t row;
        row.name  = name;
        row.opA   = a;
        row.opB   = b;
        row.dest  = dest;
        row.op    = op;
        row.expLo = expected[31:0];
        row.expHi = expected[63:32];
        opTable.push_back(row);
    endtask

    task automatic buildTable();
        word_t ra;
        word_t rb;
        addRow("add small", 32'd5, 32'd7, 4'd4, opAdd, 64'd12);
        addRow("add wrap", 32'hffff_ffff, 32'd2, 4'd5, opAdd, 64'd1);
        addRow("sub small", 32'd10, 32'd3, 4'd6, opSub, 64'd7);
        addRow("sub wrap", 32'd3, 32'd10, 4'd7, opSub, 64'h0000_0000_ffff_fff9);
        addRow("and mask", 32'hf0f0_a5a5, 32'h0ff0_ff00, 4'd8, opAnd, 64'h00f0_a500);
        addRow("or halves", 32'hf000_0000, 32'h0000_000f, 4'd9, opOr, 64'hf000_000f);
        addRow("shl reference", 32'd24, 32'd2, 4'd10, opShl, 64'd96);
        addRow("shl by zero", 32'h1234, 32'h20, 4'd11, opShl, 64'h1234);   // low 5 bits zero
        addRow("shr full", 32'h8000_0000, 32'd31, 4'd12, opShr, 64'd1);
        addRow("mul small", 32'd3, 32'd5, 4'd13, opMul, 64'd15);
        addRow("mul max", 32'hffff_ffff, 32'hffff_ffff, 4'd14, opMul, 64'hffff_fffe_0000_0001);
        ra = $urandom;
        rb = $urandom;
        addRow("add random", ra, rb, 4'd15, opAdd, expectedResult(opAdd, ra, rb));
        addRow("and random", rb, ra, 4'd0, opAnd, expectedResult(opAnd, rb, ra));
        ra = $urandom;
        rb = $urandom;
        addRow("shl random", ra, rb, 4'd1, opShl, expectedResult(opShl, ra, rb));
        addRow("shr random", rb, ra, 4'd2, opShr, expectedResult(opShr, rb, ra));
        ra = $urandom;
        rb = $urandom;
        addRow("mul random one", ra, rb, 4'd3, opMul, expectedResult(opMul, ra, rb));
        ra = $urandom;
        rb = $urandom;
        addRow("mul random two", ra, rb, 4'd4, opMul, expectedResult(opMul, ra, rb));
    endtask

    task automatic clearControls();
        outSel  = '0;
        loadSel = '0;
        start   = 1'b0;
    endtask

    task automatic checkValue(string name, word_t expected, word_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // called just after a falling edge and samples well before the next rising edge
    task automatic readBus(string name, busSource_t src, regSel_t idx, word_t expected);
        outSel = src;
        regSel = idx;
        #10;
        checkValue(name, expected, busOut);
        @(negedge Clock);
        clearControls();
    endtask

    task automatic loadFromMemory(word_t value);
        mdataIn      = value;
        loadSel.read = 1'b1;
        loadSel.mdr  = 1'b1;
        @(negedge Clock);
        clearControls();
    endtask

    task automatic loadRegister(regSel_t idx, word_t value);
        loadFromMemory(value);
        outSel.mdr = 1'b1;   // MDR over the bus into the register file
        loadSel.rf = 1'b1;
        regSel     = idx;
        @(negedge Clock);
        clearControls();
    endtask

    task automatic waitFinished(string name, output bit done, output int latency);
        int cycles;
        cycles = 0;
        while (finished !== 1'b1 && cycles < waitLimit) begin
            @(negedge Clock);
            cycles++;
        end
        done    = (finished === 1'b1);
        latency = cycles + 1;   // the start edge opens the first cycle
        if (!done) begin
            errorCount++;
            timeoutCount++;
            $display("timeout in %s: finished did not rise within %0d cycles", name, waitLimit);
        end
    endtask

    task automatic runRow(opRow_t row, output bit done);
        int latency;
        loadRegister(regSel_t'(2), row.opA);
        loadRegister(regSel_t'(3), row.opB);
        outSel.rf  = 1'b1;   // register 2 into RY as operand A
        regSel     = regSel_t'(2);
        loadSel.ry = 1'b1;
        @(negedge Clock);
        clearControls();
        outSel.rf = 1'b1;    // register 3 is operand B at the start edge
        regSel    = regSel_t'(3);
        opSelect  = row.op;
        start     = 1'b1;
        @(negedge Clock);
        clearControls();
        loadSel.rz = 1'b1;   // RZ tracks the ALU until the result is final
        waitFinished(row.name, done, latency);
        if (done) begin
            checkValue({row.name, " latency"},
                       word_t'(expectedLatency(row.op, row.opB)), word_t'(latency));
            @(negedge Clock);
            checkValue({row.name, " finished pulse"}, '0, word_t'(finished));
            clearControls();
            outSel.rzLo = 1'b1;
            loadSel.rf  = 1'b1;
            regSel      = row.dest;
            @(negedge Clock);
            clearControls();
            readBus({row.name, " low"}, fromRf, row.dest, row.expLo);
            readBus({row.name, " high"}, fromRzHi, '0, row.expHi);
        end else begin
            clearControls();
        end
    endtask

    initial begin
        bit done;
        void'($urandom(32'h1f98));
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        rstN         = 1'b0;
        regSel       = '0;
        opSelect     = opAdd;
        mdataIn      = '0;
        clearControls();
        repeat (10) @(negedge Clock);
        rstN = 1'b1;
        @(negedge Clock);

        readBus("empty bus after reset", noSource, '0, '0);
        readBus("pc after reset", fromPc, '0, '0);
        loadSel.incPc = 1'b1;
        repeat (3) @(negedge Clock);
        clearControls();
        readBus("pc after three increments", fromPc, '0, 32'd3);
        loadFromMemory(32'h0000_0400);
        outSel.mdr = 1'b1;   // jump target over the bus
        loadSel.pc = 1'b1;
        @(negedge Clock);
        clearControls();
        readBus("pc load", fromPc, '0, 32'h0000_0400);
        loadFromMemory(32'h8a5c_3e17);
        outSel.mdr = 1'b1;
        loadSel.ir = 1'b1;
        @(negedge Clock);
        clearControls();
        readBus("ir load", fromIr, '0, 32'h8a5c_3e17);

        for (int i = 0; i < `DP_REG_COUNT; i++) begin
            regValues[i] = $urandom;
            loadRegister(regSel_t'(i), regValues[i]);
            readBus($sformatf("register %0d", i), fromRf, regSel_t'(i), regValues[i]);
        end
        // second pass shows no load disturbed another entry
        for (int i = 0; i < `DP_REG_COUNT; i++) begin
            readBus($sformatf("register %0d kept", i), fromRf, regSel_t'(i), regValues[i]);
        end

        buildTable();
        for (int i = 0; i < opTable.size() && timeoutCount == 0; i++) begin
            runRow(opTable[i], done);
        end
        readBus("empty bus after operations", noSource, '0, '0);

        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/datapathPkg.sv
logic/registerFile.sv
logic/specialRegisters.sv
logic/busMux.sv
logic/alu.sv
logic/dataPath.sv
verification/dataPathTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the datapath testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module dataPathTb -o simDataPath
simOutput="$(./obj_dir/simDataPath)"
echo "$simOutput"
if echo "$simOutput" | grep -q "RESULT: PASS"; then
    exit 0
else
    exit 1
fi
